//--- Makefile
# Verilator build and run of the gpu_mem testbench, from the project root
TOP = tb_gpu_mem

.PHONY: run lint clean

run:
	verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- list.f
+incdir+src
src/gpu_mem_pkg.sv
src/instr_decode.sv
src/word_shuffle.sv
src/line_builder.sv
src/fma_issue.sv
src/escape_tracker.sv
src/gpu_mem_top.sv
sim/tb_gpu_mem.sv

//--- sim/gpu_mem_golden.txt
// kind wb_valid wb_line reg_a reg_b n instr0 instr1 instr2 exp_abc exp_iters exp_addr exp_flags
// flags from bit 4 down: abc_valid use_new_c fma_output_valid frame_swap iters_valid
// kinds: 1 reset 2 loadi/write 3 load 4 loadb 5 escape 6 senditers 7 fbswap/no-ops
// outputs are sampled one cycle after the last instruction, all values in hex
1 0 000000000000000000000000 0000 0000 0 00000000 00000000 00000000 000000000000000000000000 ff 00000 00
2 0 000000000000000000000000 0000 0000 3 70111100 71222200 72333300 000000000000000000000000 ff 00000 00
2 0 000000000000000000000000 0000 0000 3 73444400 74555500 75666600 000000000000000000000000 ff 00000 00
2 0 000000000000000000000000 0000 0000 1 c1000010 00000000 00000000 111122223333444455556666 ff 00000 1c
2 0 000000000000000000000000 0000 0000 1 c0000000 00000000 00000000 111122223333444455556666 ff 00000 10
3 0 000000000000000000000000 0000 0400 2 a1008000 c0000000 00000000 111104003333444404806666 ff 00000 10
3 0 000000000000000000000000 0000 ff00 2 a2020000 c1000000 00000000 11110400ff00444404800100 ff 00000 18
4 1 01230a000210700100500060 0000 0000 2 9100005f c0000000 00000000 01230420fedd0a00e002f600 ff 00000 10
4 0 000000000000000000000000 0000 0000 2 90000093 c0000000 00000000 0000042000500000e0020060 ff 00000 10
4 0 000000000000000000000000 0000 0000 2 940000ed c0000000 00000000 0246fdf0ffb014008fffffa0 ff 00000 10
5 1 00000000000000008fff1000 0014 0000 1 d0000000 00000000 00000000 0246fdf0ffb014008fffffa0 ff 00000 00
5 1 000000000000000090002000 0028 0007 2 d0000000 e0000000 00000000 0246fdf0ffb014008fffffa0 a5 03207 01
6 0 000000000000000000000000 013f 013f 1 e0000000 00000000 00000000 0246fdf0ffb014008fffffa0 ff 18fff 01
7 0 000000000000000000000000 0000 0000 1 60000000 00000000 00000000 0246fdf0ffb014008fffffa0 ff 18fff 02
7 0 000000000000000000000000 0000 0000 3 00000000 31234500 f0000000 0246fdf0ffb014008fffffa0 ff 18fff 00
7 0 000000000000000000000000 0000 0000 3 10000000 2abcdef0 45678901 0246fdf0ffb014008fffffa0 ff 18fff 00

//--- sim/tb_gpu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_mem_config.svh"

module tb_gpu_mem;

    // ------------------------------
    // run limits and record layout
    // ------------------------------
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_TEST = 50;
    localparam int MAX_TESTS       = 32;
    localparam int MAX_INSTRS      = 3;
    // hex values on one golden line
    localparam int REC_WORDS       = 13;
    localparam int LINE_BITS       = `GPU_LINE_WORDS * `GPU_WORD_WIDTH;
    localparam int ITERS_BITS      = `GPU_FMA_COUNT * `GPU_ITERS_BITS;
    localparam int ADDR_BITS       = $bits(gpu_mem_pkg::pix_addr_t);

    // value offsets inside one record
    localparam int F_KIND  = 0;
    localparam int F_WBV   = 1;
    localparam int F_WB    = 2;
    localparam int F_REGA  = 3;
    localparam int F_REGB  = 4;
    localparam int F_COUNT = 5;
    localparam int F_INSTR = 6;
    localparam int F_ABC   = 9;
    localparam int F_ITERS = 10;
    localparam int F_ADDR  = 11;
    localparam int F_FLAGS = 12;

    logic                        clk_in;
    logic                        rst_in;
    logic [`GPU_INSTR_WIDTH-1:0] instr;
    logic                        instr_valid;
    gpu_mem_pkg::word_t          reg_a;
    gpu_mem_pkg::word_t          reg_b;
    gpu_mem_pkg::line_t          wb_line;
    logic                        wb_valid;
    gpu_mem_pkg::line_t          abc;
    logic                        abc_valid;
    logic                        use_new_c;
    logic                        fma_output_valid;
    logic                        frame_swap;
    gpu_mem_pkg::iters_t         iters;
    logic                        iters_valid;
    gpu_mem_pkg::pix_addr_t      pix_addr;

    // all records back to back
    logic [LINE_BITS-1:0] golden [MAX_TESTS*REC_WORDS];
    int                   num_tests;
    int                   error_count;
    int                   failed_tests;
    logic                 loaded;

    gpu_mem_top gpu_mem_top_inst (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .instr            (instr),
        .instr_valid      (instr_valid),
        .reg_a            (reg_a),
        .reg_b            (reg_b),
        .wb_line          (wb_line),
        .wb_valid         (wb_valid),
        .abc              (abc),
        .abc_valid        (abc_valid),
        .use_new_c        (use_new_c),
        .fma_output_valid (fma_output_valid),
        .frame_swap       (frame_swap),
        .iters            (iters),
        .iters_valid      (iters_valid),
        .pix_addr         (pix_addr)
    );

    initial begin
        clk_in = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_in = ~clk_in;
        end
    end

    // watchdog, sized from the number of records
    initial begin
        wait (loaded);
        repeat (num_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk_in);
        $display("timeout: tests still running after %0d cycles",
                 num_tests * CYCLES_PER_TEST + RESET_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic kind_known(input logic [7:0] kind);
        return (kind >= 8'd1) && (kind <= 8'd7);
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            1: return "reset state";
            2: return "loadi and write";
            3: return "load with step";
            4: return "loadb shuffle";
            5: return "escape test";
            6: return "senditers";
            7: return "fbswap and no-ops";
            default: return "unknown";
        endcase
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_line(input string name, input gpu_mem_pkg::line_t got,
                              input gpu_mem_pkg::line_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_iters(input string name, input gpu_mem_pkg::iters_t got,
                               input gpu_mem_pkg::iters_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input gpu_mem_pkg::pix_addr_t got,
                              input gpu_mem_pkg::pix_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // ------------------------------
    // stimulus, one falling edge per step
    // ------------------------------
    task automatic capture_buffer(input gpu_mem_pkg::line_t line);
        wb_line  = line;
        wb_valid = 1'b1;
        @(negedge clk_in);
        wb_valid = 1'b0;
    endtask

    task automatic issue_instr(input logic [`GPU_INSTR_WIDTH-1:0] word);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk_in);
        instr_valid = 1'b0;
    endtask

    task automatic run_test(input int t);
        int         base;
        int         kind;
        int         count;
        int         errors_before;
        logic [7:0] flags;

        base          = t * REC_WORDS;
        kind          = int'(golden[base + F_KIND][7:0]);
        count         = int'(golden[base + F_COUNT][7:0]);
        flags         = golden[base + F_FLAGS][7:0];
        errors_before = error_count;

        // controller registers stay put for the whole sequence
        reg_a = golden[base + F_REGA][`GPU_WORD_WIDTH-1:0];
        reg_b = golden[base + F_REGB][`GPU_WORD_WIDTH-1:0];
        if (golden[base + F_WBV][0]) begin
            capture_buffer(golden[base + F_WB]);
        end
        for (int i = 0; i < count && i < MAX_INSTRS; i++) begin
            issue_instr(golden[base + F_INSTR + i][`GPU_INSTR_WIDTH-1:0]);
        end

        // one cycle after the last instruction
        check_line("abc", abc, golden[base + F_ABC]);
        check_iters("iters", iters, golden[base + F_ITERS][ITERS_BITS-1:0]);
        check_addr("pix_addr", pix_addr, golden[base + F_ADDR][ADDR_BITS-1:0]);
        check_flag("abc_valid", abc_valid, flags[4]);
        check_flag("use_new_c", use_new_c, flags[3]);
        check_flag("fma_output_valid", fma_output_valid, flags[2]);
        check_flag("frame_swap", frame_swap, flags[1]);
        check_flag("iters_valid", iters_valid, flags[0]);

        // strobes drop again, use_new_c is a level
        @(negedge clk_in);
        check_flag("abc_valid", abc_valid, 1'b0);
        check_flag("fma_output_valid", fma_output_valid, 1'b0);
        check_flag("frame_swap", frame_swap, 1'b0);
        check_flag("iters_valid", iters_valid, 1'b0);
        check_flag("use_new_c", use_new_c, flags[3]);

        if (error_count == errors_before) begin
            $display("test %0d (%s): pass", t, kind_name(kind));
        end else begin
            $display("test %0d (%s): FAIL with %0d mismatches", t, kind_name(kind),
                     error_count - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        rst_in       = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        reg_a        = '0;
        reg_b        = '0;
        wb_line      = '0;
        wb_valid     = 1'b0;
        error_count  = 0;
        failed_tests = 0;
        num_tests    = 0;
        loaded       = 1'b0;

        $readmemh("sim/gpu_mem_golden.txt", golden);
        // records end at the first line without a known kind
        while (num_tests < MAX_TESTS &&
               kind_known(golden[num_tests * REC_WORDS + F_KIND][7:0])) begin
            num_tests++;
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("summary: %0d tests run, %0d passed, %0d failed, %0d mismatches",
                 num_tests, num_tests - failed_tests, failed_tests, error_count);
        if (num_tests > 0 && error_count == 0) begin
            $display("All checks passed");
        end else begin
            if (num_tests == 0) begin
                $display("no test records could be read from sim/gpu_mem_golden.txt");
            end
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/escape_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_mem_config.svh"

module escape_tracker (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire                     do_or,
    input  wire                     do_senditers,
    input  wire gpu_mem_pkg::line_t captured,
    input  wire gpu_mem_pkg::word_t reg_a,
    input  wire gpu_mem_pkg::word_t reg_b,
    output gpu_mem_pkg::iters_t     iters,
    output logic                    iters_valid,
    output gpu_mem_pkg::pix_addr_t  pix_addr
);

    // phrase 3 carries |z|^2 for each fma
    localparam int PHRASE3_BASE = 2 * `GPU_FMA_COUNT;
    // |z|^2 >= 4 in fixed point means the pixel escaped
    localparam gpu_mem_pkg::word_t ESC_LIMIT =
        gpu_mem_pkg::word_t'(4 << `GPU_FIXED_POINT);

    // all ones per nibble means not escaped yet
    gpu_mem_pkg::iters_t pending;
    // phrase 3 words with the sign bit dropped
    gpu_mem_pkg::word_t  magnitude [`GPU_FMA_COUNT];

    always_comb begin
        for (int f = 0; f < `GPU_FMA_COUNT; f++) begin
            magnitude[f] = {1'b0, captured[PHRASE3_BASE + f][`GPU_WORD_WIDTH-2:0]};
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pending     <= '1;
            iters       <= '1;
            iters_valid <= 1'b0;
            pix_addr    <= '0;
        end else begin
            iters_valid <= do_senditers;

            if (do_or) begin
                for (int f = 0; f < `GPU_FMA_COUNT; f++) begin
                    // first escape wins
                    if (pending[f] == '1 && magnitude[f] >= ESC_LIMIT) begin
                        // iteration count divided by 4 to fit the nibble
                        pending[f] <= reg_a[2 +: `GPU_ITERS_BITS];
                    end
                end
            end else if (do_senditers) begin
                iters    <= pending;
                // column-major address from the two controller registers
                pix_addr <= gpu_mem_pkg::pix_addr_t'(`GPU_HEIGHT * reg_a + reg_b);
                // start the next pixel pair fresh
                pending  <= '1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fma_issue.sv
`timescale 1ns/1ps
`default_nettype none

module fma_issue (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire                          do_write,
    input  wire gpu_mem_pkg::reg_field_t ra,
    input  wire gpu_mem_pkg::reg_field_t rb,
    input  wire gpu_mem_pkg::line_t      stage_line,
    output gpu_mem_pkg::line_t           abc,
    output logic                         abc_valid,
    output logic                         use_new_c,
    output logic                         fma_output_valid
);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            abc              <= '0;
            abc_valid        <= 1'b0;
            use_new_c        <= 1'b0;
            fma_output_valid <= 1'b0;
        end else begin
            // single-cycle strobes toward the fmas
            abc_valid        <= do_write;
            // fma result only counts at the end of a chained dot product
            fma_output_valid <= do_write && (rb == 4'd1);
            if (do_write) begin
                abc       <= stage_line;
                // level, holds until the next write
                // 1 takes c from the line, else the fma reuses its last c
                use_new_c <= (ra == 4'd1);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/gpu_mem_config.svh
`ifndef GPU_MEM_CONFIG_SVH
`define GPU_MEM_CONFIG_SVH

// ------------------------------
// datapath sizing
// ------------------------------

// fma units fed by one staging line
`define GPU_FMA_COUNT 2

// bits per fixed-point word
`define GPU_WORD_WIDTH 16

// fraction bits of a word
`define GPU_FIXED_POINT 10

// three operand slots (a, b, c) per fma
`define GPU_LINE_WORDS 6

// escape iteration bits kept per pixel
`define GPU_ITERS_BITS 4

// ------------------------------
// screen and controller
// ------------------------------

// frame buffer is 320 x 320 pixels
`define GPU_WIDTH 320
`define GPU_HEIGHT 320

// controller instruction width
`define GPU_INSTR_WIDTH 32

`endif

//--- src/gpu_mem_pkg.sv
`default_nettype none

`include "gpu_mem_config.svh"

package gpu_mem_pkg;

    // one fixed-point operand or result
    typedef logic [`GPU_WORD_WIDTH-1:0] word_t;

    // staging line, word 0 sits in the top bits
    // word index = fma * 3 + slot (a=0, b=1, c=2)
    typedef word_t [0:`GPU_LINE_WORDS-1] line_t;

    // register index in an instruction, also used as a shuffle code
    typedef logic [3:0] reg_field_t;

    // per-pixel escape iterations, fma 0 in the upper nibble
    typedef logic [0:`GPU_FMA_COUNT-1][`GPU_ITERS_BITS-1:0] iters_t;

    // frame buffer address, wide enough for the whole screen
    typedef logic [$clog2(`GPU_WIDTH*`GPU_HEIGHT)-1:0] pix_addr_t;

    // controller opcodes
    // most are handled by the controller itself and are no-ops here
    typedef enum logic [3:0] {
        OP_NOP       = 4'b0000,
        OP_END       = 4'b0001,
        OP_XOR       = 4'b0010,
        OP_ADDI      = 4'b0011,
        OP_BGE       = 4'b0100,
        OP_JUMP      = 4'b0101,
        // swap front and back frame buffer
        OP_FBSWAP    = 4'b0110,
        // immediate into word ra of the line
        OP_LOADI     = 4'b0111,
        OP_SENDL     = 4'b1000,
        // shuffle of the captured write buffer into the line
        OP_LOADB     = 4'b1001,
        // reg_b + fma * imm into slot ra of every fma
        OP_LOAD      = 4'b1010,
        OP_WRITEB    = 4'b1011,
        // issue the line to the fmas
        OP_WRITE     = 4'b1100,
        // escape test on the captured magnitudes
        OP_OR        = 4'b1101,
        // emit iterations and pixel address
        OP_SENDITERS = 4'b1110,
        OP_PAUSE     = 4'b1111
    } opcode_e;

endpackage

`default_nettype wire

//--- src/gpu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_mem_config.svh"

module gpu_mem_top (
    input  wire                        clk_in,
    input  wire                        rst_in,
    input  wire [`GPU_INSTR_WIDTH-1:0] instr,
    input  wire                        instr_valid,
    input  wire gpu_mem_pkg::word_t    reg_a,
    input  wire gpu_mem_pkg::word_t    reg_b,
    input  wire gpu_mem_pkg::line_t    wb_line,
    input  wire                        wb_valid,
    output gpu_mem_pkg::line_t         abc,
    output logic                       abc_valid,
    output logic                       use_new_c,
    output logic                       fma_output_valid,
    output logic                       frame_swap,
    output gpu_mem_pkg::iters_t        iters,
    output logic                       iters_valid,
    output gpu_mem_pkg::pix_addr_t     pix_addr
);

    // ------------------------------
    // decoded instruction
    // ------------------------------
    logic                    do_loadi;
    logic                    do_load;
    logic                    do_loadb;
    logic                    do_write;
    logic                    do_or;
    logic                    do_senditers;
    gpu_mem_pkg::reg_field_t ra;
    gpu_mem_pkg::reg_field_t rb;
    gpu_mem_pkg::reg_field_t rc;
    gpu_mem_pkg::word_t      imm;

    // staging line and write buffer snapshot
    gpu_mem_pkg::line_t      stage_line;
    gpu_mem_pkg::line_t      captured;

    instr_decode instr_decode_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .do_loadi     (do_loadi),
        .do_load      (do_load),
        .do_loadb     (do_loadb),
        .do_write     (do_write),
        .do_or        (do_or),
        .do_senditers (do_senditers),
        .ra           (ra),
        .rb           (rb),
        .rc           (rc),
        .imm          (imm),
        .frame_swap   (frame_swap)
    );

    line_builder line_builder_inst (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .wb_line    (wb_line),
        .wb_valid   (wb_valid),
        .do_loadi   (do_loadi),
        .do_load    (do_load),
        .do_loadb   (do_loadb),
        .ra         (ra),
        .rb         (rb),
        .rc         (rc),
        .imm        (imm),
        .reg_b      (reg_b),
        .stage_line (stage_line),
        .captured   (captured)
    );

    // operand issue toward the two fmas
    fma_issue fma_issue_inst (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .do_write         (do_write),
        .ra               (ra),
        .rb               (rb),
        .stage_line       (stage_line),
        .abc              (abc),
        .abc_valid        (abc_valid),
        .use_new_c        (use_new_c),
        .fma_output_valid (fma_output_valid)
    );

    // escape bookkeeping and frame buffer writes
    escape_tracker escape_tracker_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .do_or        (do_or),
        .do_senditers (do_senditers),
        .captured     (captured),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .iters        (iters),
        .iters_valid  (iters_valid),
        .pix_addr     (pix_addr)
    );

endmodule

`default_nettype wire

//--- src/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_mem_config.svh"

module instr_decode (
    input  wire                           clk_in,
    input  wire                           rst_in,
    input  wire [`GPU_INSTR_WIDTH-1:0]    instr,
    input  wire                           instr_valid,
    output logic                          do_loadi,
    output logic                          do_load,
    output logic                          do_loadb,
    output logic                          do_write,
    output logic                          do_or,
    output logic                          do_senditers,
    output gpu_mem_pkg::reg_field_t       ra,
    output gpu_mem_pkg::reg_field_t       rb,
    output gpu_mem_pkg::reg_field_t       rc,
    output gpu_mem_pkg::word_t            imm,
    output logic                          frame_swap
);

    gpu_mem_pkg::opcode_e opcode;
    logic                 do_fbswap;

    // layout from the top: opcode | ra | imm | rb | rc
    assign opcode = gpu_mem_pkg::opcode_e'(instr[31:28]);
    assign ra     = instr[27:24];
    assign imm    = instr[23:8];
    assign rb     = instr[7:4];
    assign rc     = instr[3:0];

    // one-hot strobes, only while the instruction is valid
    always_comb begin
        do_loadi     = 1'b0;
        do_load      = 1'b0;
        do_loadb     = 1'b0;
        do_write     = 1'b0;
        do_or        = 1'b0;
        do_senditers = 1'b0;
        do_fbswap    = 1'b0;
        if (instr_valid) begin
            case (opcode)
                gpu_mem_pkg::OP_LOADI:     do_loadi = 1'b1;
                gpu_mem_pkg::OP_LOAD:      do_load = 1'b1;
                gpu_mem_pkg::OP_LOADB:     do_loadb = 1'b1;
                gpu_mem_pkg::OP_WRITE:     do_write = 1'b1;
                gpu_mem_pkg::OP_OR:        do_or = 1'b1;
                gpu_mem_pkg::OP_SENDITERS: do_senditers = 1'b1;
                gpu_mem_pkg::OP_FBSWAP:    do_fbswap = 1'b1;
                // controller-side ops and retired bram ops do nothing here
                default: begin
                end
            endcase
        end
    end

    // frame swap goes straight out, one cycle after the instruction
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            frame_swap <= 1'b0;
        end else begin
            frame_swap <= do_fbswap;
        end
    end

endmodule

`default_nettype wire

//--- src/line_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_mem_config.svh"

module line_builder (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire gpu_mem_pkg::line_t      wb_line,
    input  wire                          wb_valid,
    input  wire                          do_loadi,
    input  wire                          do_load,
    input  wire                          do_loadb,
    input  wire gpu_mem_pkg::reg_field_t ra,
    input  wire gpu_mem_pkg::reg_field_t rb,
    input  wire gpu_mem_pkg::reg_field_t rc,
    input  wire gpu_mem_pkg::word_t      imm,
    input  wire gpu_mem_pkg::word_t      reg_b,
    output gpu_mem_pkg::line_t           stage_line,
    output gpu_mem_pkg::line_t           captured
);

    // a, b, c per fma
    localparam int SLOTS = `GPU_LINE_WORDS / `GPU_FMA_COUNT;

    gpu_mem_pkg::reg_field_t slot_code [SLOTS];
    gpu_mem_pkg::word_t      shuf_word [`GPU_LINE_WORDS];
    logic                    shuf_hold [`GPU_LINE_WORDS];
    gpu_mem_pkg::word_t      load_word [`GPU_FMA_COUNT];

    // each slot has its own shuffle code field
    assign slot_code[0] = ra;
    assign slot_code[1] = rb;
    assign slot_code[2] = rc;

    // ------------------------------
    // per-word shuffle and load values
    // ------------------------------
    for (genvar f = 0; f < `GPU_FMA_COUNT; f++) begin : fma_gen
        localparam gpu_mem_pkg::word_t FMA_IDX = gpu_mem_pkg::word_t'(f);

        // base plus fma index times step, spreads pixels across fmas
        assign load_word[f] = reg_b + FMA_IDX * imm;

        for (genvar s = 0; s < SLOTS; s++) begin : slot_gen
            // past results of this fma, phrase k at word k * fma_count + f
            word_shuffle word_shuffle_inst (
                .code  (slot_code[s]),
                .past0 (captured[f]),
                .past1 (captured[`GPU_FMA_COUNT + f]),
                .past2 (captured[2*`GPU_FMA_COUNT + f]),
                .word  (shuf_word[f*SLOTS + s]),
                .hold  (shuf_hold[f*SLOTS + s])
            );
        end
    end

    // ------------------------------
    // capture and staging registers
    // ------------------------------
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            captured   <= '0;
            stage_line <= '0;
        end else begin
            // write buffer snapshot, used from the next cycle on
            if (wb_valid) begin
                captured <= wb_line;
            end

            if (do_loadi) begin
                // ra picks the word directly, indexes past the line are dropped
                if (ra < `GPU_LINE_WORDS) begin
                    stage_line[ra] <= imm;
                end
            end else if (do_load) begin
                if (ra < SLOTS) begin
                    for (int f = 0; f < `GPU_FMA_COUNT; f++) begin
                        stage_line[f*SLOTS + int'(ra)] <= load_word[f];
                    end
                end
            end else if (do_loadb) begin
                // codes 7..12 keep what was staged before
                for (int i = 0; i < `GPU_LINE_WORDS; i++) begin
                    if (!shuf_hold[i]) begin
                        stage_line[i] <= shuf_word[i];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/word_shuffle.sv
`timescale 1ns/1ps
`default_nettype none

module word_shuffle (
    input  wire gpu_mem_pkg::reg_field_t code,
    input  wire gpu_mem_pkg::word_t      past0,
    input  wire gpu_mem_pkg::word_t      past1,
    input  wire gpu_mem_pkg::word_t      past2,
    output gpu_mem_pkg::word_t           word,
    output logic                         hold
);

    // code map
    //   0       zero
    //   1..3    past0..past2
    //   4..6    doubled past0..past2, top bit dropped
    //   13..15  negated past2, past1, past0
    //   7..12   not a shuffle, keep the old word
    always_comb begin
        word = '0;
        hold = 1'b0;
        case (code)
            4'd0: word = '0;
            4'd1: word = past0;
            4'd2: word = past1;
            4'd3: word = past2;
            4'd4: word = past0 << 1;
            4'd5: word = past1 << 1;
            4'd6: word = past2 << 1;
            // two's complement, same fixed point
            4'd13: word = -past2;
            4'd14: word = -past1;
            4'd15: word = -past0;
            default: hold = 1'b1;
        endcase
    end

endmodule

`default_nettype wire
